/* logic/act_skew.sv */
`include "tpu_defs.svh"

module act_skew
    import tpu_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_i,
    input  logic      stall_i,
    input  act_beat_t beat_i,
    output act_vec_t  act_o,
    output logic      valid_o
);

    localparam int N  = `TPU_N;
    localparam int AB = `TPU_A_BITS;

    act_vec_t     col_in;
    logic [N-2:0] vld_q;    // follows column N-1 through the skew

    assign col_in = beat_i.valid ? beat_i.vec : '0;    // invalid beats carry zeros

    for (genvar j = 0; j < N; j++) begin : g_col
        if (j == 0) begin : g_wire
            assign act_o[j] = col_in[j];
        end else begin : g_dly
            logic [AB-1:0] pipe_q [j];

            always_ff @(posedge clk_i) begin
                if (rst_i) begin
                    for (int k = 0; k < j; k++) begin
                        pipe_q[k] <= '0;
                    end
                end else if (!stall_i) begin
                    pipe_q[0] <= col_in[j];
                    for (int k = 1; k < j; k++) begin
                        pipe_q[k] <= pipe_q[k-1];
                    end
                end
            end

            assign act_o[j] = pipe_q[j-1];
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            vld_q <= '0;
        end else if (!stall_i) begin
            vld_q[0] <= beat_i.valid;
            for (int k = 1; k < N - 1; k++) begin
                vld_q[k] <= vld_q[k-1];
            end
        end
    end

    assign valid_o = vld_q[N-2];

endmodule

/* logic/mac_cell.sv */
`include "tpu_defs.svh"

module mac_cell (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   stall_i,
    input  logic                   wt_shift_i,
    input  logic                   bank_sel_i,
    input  logic [`TPU_W_BITS-1:0] wt_i,
    input  logic [`TPU_A_BITS-1:0] act_i,
    input  logic [`TPU_R_BITS-1:0] psum_i,
    output logic [`TPU_R_BITS-1:0] psum_o,
    output logic [`TPU_A_BITS-1:0] act_o,
    output logic [`TPU_W_BITS-1:0] wt_o
);

    localparam int WB = `TPU_W_BITS;
    localparam int AB = `TPU_A_BITS;
    localparam int RB = `TPU_R_BITS;

    logic [WB-1:0]    wt_q [2];
    logic [WB-1:0]    wt_act;
    logic [AB-1:0]    act_q;
    logic [RB-1:0]    sum_q;
    logic [WB+AB-1:0] prod;

    assign wt_act = wt_q[bank_sel_i];
    assign wt_o   = wt_q[!bank_sel_i];    // shadow weight feeds the row above
    assign prod   = act_i * wt_act;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wt_q[0] <= '0;
            wt_q[1] <= '0;
            act_q   <= '0;
            sum_q   <= '0;
        end else if (!stall_i) begin
            if (wt_shift_i) begin
                wt_q[!bank_sel_i] <= wt_i;
            end
            act_q <= act_i;                  // on to the row below
            sum_q <= psum_i + RB'(prod);     // wraps at result width
        end
    end

    assign psum_o = sum_q;
    assign act_o  = act_q;

    // a shift strobe that meets a stall must not disturb the shadow weight
    a_stall_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        (stall_i && wt_shift_i) |=> $stable(wt_o));

endmodule

/* logic/result_deskew.sv */
`include "tpu_defs.svh"

module result_deskew
    import tpu_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_i,
    input  logic      stall_i,
    input  res_vec_t  row_res_i,
    input  logic      valid_i,
    output res_beat_t res_o
);

    localparam int N  = `TPU_N;
    localparam int RB = `TPU_R_BITS;

    // one stage covers row 0 inside the array and N-1 stages its deskew
    logic [N-1:0] vld_q;

    for (genvar r = 0; r < N; r++) begin : g_row
        if (r == N - 1) begin : g_wire
            assign res_o.vec[r] = row_res_i[r];    // last row arrives last
        end else begin : g_dly
            logic [RB-1:0] pipe_q [N-1-r];

            always_ff @(posedge clk_i) begin
                if (!stall_i) begin
                    pipe_q[0] <= row_res_i[r];
                    for (int k = 1; k < N - 1 - r; k++) begin
                        pipe_q[k] <= pipe_q[k-1];
                    end
                end
            end

            assign res_o.vec[r] = pipe_q[N-2-r];
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            vld_q <= '0;
        end else if (!stall_i) begin
            vld_q <= {vld_q[N-2:0], valid_i};
        end
    end

    assign res_o.valid = vld_q[N-1];

endmodule

/* logic/systolic_array.sv */
`include "tpu_defs.svh"

module systolic_array
    import tpu_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_i,
    input  logic     stall_i,
    input  logic     wt_shift_i,
    input  logic     bank_sel_i,
    input  wt_vec_t  wt_row_i,
    input  act_vec_t act_i,
    output res_vec_t row_res_o
);

    localparam int N  = `TPU_N;
    localparam int RB = `TPU_R_BITS;

    wt_vec_t       wt_up  [N+1];       // wt_up[r] holds the shadow row of grid row r
    act_vec_t      act_dn [N+1];       // act_dn[r] enters grid row r
    logic [RB-1:0] psum   [N][N+1];

    assign wt_up[N]  = wt_row_i;       // new rows enter at the bottom
    assign act_dn[0] = act_i;

    for (genvar r = 0; r < N; r++) begin : g_row
        assign psum[r][0]   = '0;
        assign row_res_o[r] = psum[r][N];

        for (genvar c = 0; c < N; c++) begin : g_col
            mac_cell i_cell (
                .clk_i      (clk_i),
                .rst_i      (rst_i),
                .stall_i    (stall_i),
                .wt_shift_i (wt_shift_i),
                .bank_sel_i (bank_sel_i),
                .wt_i       (wt_up[r+1][c]),
                .act_i      (act_dn[r][c]),
                .psum_i     (psum[r][c]),
                .psum_o     (psum[r][c+1]),
                .act_o      (act_dn[r+1][c]),
                .wt_o       (wt_up[r][c])
            );
        end
    end

endmodule

/* logic/tpu_core.sv */
module tpu_core
    import tpu_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_i,
    input  logic      stall_i,
    input  logic      wt_load_i,
    input  wt_vec_t   wt_row_i,
    input  logic      next_tile_i,
    input  act_beat_t act_i,
    output res_beat_t res_o,
    output logic      shadow_full_o
);

    logic     wt_shift;
    logic     bank_sel;
    wt_vec_t  wt_row_q;
    act_vec_t act_skewed;
    logic     skew_valid;
    res_vec_t row_res;

    // row data waits one cycle to meet the lagged shift strobe
    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            wt_row_q <= wt_row_i;
        end
    end

    weight_bank_ctrl i_ctrl (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .stall_i       (stall_i),
        .wt_load_i     (wt_load_i),
        .next_tile_i   (next_tile_i),
        .wt_shift_o    (wt_shift),
        .bank_sel_o    (bank_sel),
        .shadow_full_o (shadow_full_o)
    );

    act_skew i_skew (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .stall_i (stall_i),
        .beat_i  (act_i),
        .act_o   (act_skewed),
        .valid_o (skew_valid)    // last column enters the grid
    );

    systolic_array i_array (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .stall_i    (stall_i),
        .wt_shift_i (wt_shift),
        .bank_sel_i (bank_sel),
        .wt_row_i   (wt_row_q),
        .act_i      (act_skewed),
        .row_res_o  (row_res)
    );

    result_deskew i_deskew (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .stall_i   (stall_i),
        .row_res_i (row_res),
        .valid_i   (skew_valid),
        .res_o     (res_o)
    );

endmodule

/* logic/tpu_defs.svh */
`ifndef TPU_DEFS_SVH
`define TPU_DEFS_SVH

// the grid is TPU_N by TPU_N cells
`define TPU_N 4

// operand widths in bits
`define TPU_W_BITS 8
`define TPU_A_BITS 8

// results and partial sums wrap at this width
`define TPU_R_BITS 32

`endif

/* logic/tpu_pkg.sv */
`include "tpu_defs.svh"

package tpu_pkg;

    typedef logic [`TPU_N-1:0][`TPU_W_BITS-1:0] wt_vec_t;    // one weight row
    typedef logic [`TPU_N-1:0][`TPU_A_BITS-1:0] act_vec_t;
    typedef logic [`TPU_N-1:0][`TPU_R_BITS-1:0] res_vec_t;

    typedef struct packed {
        logic     valid;
        act_vec_t vec;
    } act_beat_t;

    typedef struct packed {
        logic     valid;
        res_vec_t vec;
    } res_beat_t;

    // weight bank controller
    typedef enum logic [1:0] {
        WB_FILL = 2'd0,    // shadow bank still loading
        WB_FULL = 2'd1,
        WB_PEND = 2'd2     // swap requested early
    } wb_state_e;

endpackage

/* logic/weight_bank_ctrl.sv */
`include "tpu_defs.svh"

module weight_bank_ctrl
    import tpu_pkg::*;
(
    input  logic clk_i,
    input  logic rst_i,
    input  logic stall_i,
    input  logic wt_load_i,
    input  logic next_tile_i,
    output logic wt_shift_o,
    output logic bank_sel_o,
    output logic shadow_full_o
);

    localparam int CNT_W = $clog2(`TPU_N + 1);
    localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(`TPU_N);

    wb_state_e        state_q;
    wb_state_e        state_d;
    logic [CNT_W-1:0] cnt_q;
    logic [CNT_W-1:0] cnt_d;
    logic             started_q;    // first tile has been swapped in
    logic             bank_sel_q;
    logic             wt_shift_q;
    logic             last_load;
    logic             shadow_ready;
    logic             swap;

    assign last_load    = wt_load_i && (cnt_q == FULL_CNT - 1'b1);
    assign shadow_ready = (cnt_q == FULL_CNT);

    always_comb begin
        state_d = state_q;
        cnt_d   = cnt_q;
        swap    = 1'b0;
        unique case (state_q)
            WB_FILL: begin
                if (wt_load_i) begin
                    cnt_d = cnt_q + 1'b1;
                end
                if (next_tile_i || (last_load && !started_q)) begin
                    state_d = WB_PEND;    // first tile swaps in by itself
                end else if (last_load) begin
                    state_d = WB_FULL;
                end
            end
            WB_FULL: begin
                swap = next_tile_i;
            end
            WB_PEND: begin
                if (shadow_ready) begin
                    swap = 1'b1;
                end else if (wt_load_i) begin
                    cnt_d = cnt_q + 1'b1;
                end
            end
            default: begin
                state_d = WB_FILL;
            end
        endcase
        if (swap) begin
            state_d = WB_FILL;
            // a load in the swap cycle lands in the new shadow bank
            cnt_d   = wt_load_i ? CNT_W'(1) : '0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q    <= WB_FILL;
            cnt_q      <= '0;
            started_q  <= 1'b0;
            bank_sel_q <= 1'b0;
            wt_shift_q <= 1'b0;
        end else if (!stall_i) begin
            state_q    <= state_d;
            cnt_q      <= cnt_d;
            wt_shift_q <= wt_load_i;    // one cycle behind the host strobe
            if (swap) begin
                started_q  <= 1'b1;
                bank_sel_q <= ~bank_sel_q;
            end
        end
    end

    assign wt_shift_o    = wt_shift_q;
    assign bank_sel_o    = bank_sel_q;
    assign shadow_full_o = (state_q == WB_FULL) || ((state_q == WB_PEND) && shadow_ready);

    a_load_limit: assert property (@(posedge clk_i) disable iff (rst_i)
        (wt_load_i && !stall_i && !swap) |-> (cnt_q < FULL_CNT));

    // a swap never exposes a partly loaded bank
    a_swap_source: assert property (@(posedge clk_i) disable iff (rst_i)
        $changed(bank_sel_q) |->
            $past(shadow_ready && (state_q inside {WB_FULL, WB_PEND})));

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# build the testbench with Verilator, run it and scan the log
set -u

cd "$(dirname "$0")" || exit 1

build_dir=build
log_file=sim.log

verilator --binary --timing --assert \
    -f vlog.f \
    --top-module tb_tpu_core \
    -Mdir "$build_dir" \
    -o tb_tpu_core
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$build_dir/tb_tpu_core" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Test failures found" "$log_file"; then
    exit 1
fi
exit 0

/* tb/tb_tpu_core.sv */
`include "tpu_defs.svh"

module tb_tpu_core
    import tpu_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ns;

    localparam int N         = `TPU_N;
    localparam int RB        = `TPU_R_BITS;
    localparam int LATENCY   = 2 * N - 1;
    localparam int NUM_TESTS = 6;
    localparam logic [31:0] SEED = 32'hbace_7c21;

    typedef struct packed {
        logic [31:0] tile_seed;
        logic [31:0] n_beats;
        logic [31:0] stall_seed;    // zero runs without stalls
        logic        early;         // next_tile_i before the last row
    } test_entry_t;

    typedef struct packed {
        res_vec_t    vec;
        logic [31:0] cyc;
        logic [31:0] stalls;
    } flight_t;

    logic      clk_i;
    logic      rst_i;
    logic      stall_i;
    logic      wt_load_i;
    wt_vec_t   wt_row_i;
    logic      next_tile_i;
    act_beat_t act_i;
    res_beat_t res_o;
    logic      shadow_full_o;

    test_entry_t tests [NUM_TESTS];
    wt_vec_t     active_rows [N];    // tile the DUT computes with
    wt_vec_t     shadow_rows [N];    // tile being loaded
    flight_t     flight_q [$];
    logic [31:0] data_state;
    logic [31:0] wt_state;
    logic [31:0] stall_state;
    int          cycle_count  = 0;
    int          stall_count  = 0;
    int          beat_count   = 0;
    int          issued_count = 0;
    int          result_count = 0;
    int          check_count  = 0;
    int          error_count  = 0;

    tpu_core i_dut (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .stall_i       (stall_i),
        .wt_load_i     (wt_load_i),
        .wt_row_i      (wt_row_i),
        .next_tile_i   (next_tile_i),
        .act_i         (act_i),
        .res_o         (res_o),
        .shadow_full_o (shadow_full_o)
    );

    always #20 clk_i = ~clk_i;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic act_vec_t random_act();
        act_vec_t v;
        for (int j = 0; j < N; j++) begin
            data_state = lcg_step(data_state);
            v[j] = data_state[16 +: `TPU_A_BITS];
        end
        return v;
    endfunction

    function automatic wt_vec_t random_row();
        wt_vec_t v;
        for (int j = 0; j < N; j++) begin
            wt_state = lcg_step(wt_state);
            v[j] = wt_state[16 +: `TPU_W_BITS];
        end
        return v;
    endfunction

    function automatic logic stall_draw();
        stall_state = lcg_step(stall_state);
        return stall_state[31:30] == 2'b00;    // about one cycle in four
    endfunction

    // row r is the dot product of the beat with weight row r
    function automatic res_vec_t model_result(input act_vec_t a);
        res_vec_t res;
        for (int r = 0; r < N; r++) begin
            res[r] = '0;
            for (int j = 0; j < N; j++) begin
                res[r] = res[r] + RB'(a[j]) * RB'(active_rows[r][j]);
            end
        end
        return res;
    endfunction

    task automatic check_value(input string name, input logic [RB-1:0] actual,
                               input logic [RB-1:0] expected);
        check_count++;
        if (actual !== expected) begin
            $display("mismatch at %0t ns: %s expected %0h, got %0h",
                     $time, name, expected, actual);
            error_count++;
        end
    endtask

    task automatic apply_cycle(input logic st, input logic ld, input wt_vec_t row,
                               input logic nt, input act_beat_t beat);
        @(posedge clk_i);
        stall_i     <= st;
        wt_load_i   <= ld;
        wt_row_i    <= row;
        next_tile_i <= nt;
        act_i       <= beat;
    endtask

    task automatic idle_cycle();
        apply_cycle(1'b0, 1'b0, '0, 1'b0, '0);
    endtask

    task automatic beat_cycle();
        act_beat_t b;
        b.valid = 1'b1;
        b.vec   = random_act();
        apply_cycle(1'b0, 1'b0, '0, 1'b0, b);
        issued_count++;
    endtask

    task automatic drain_results();
        while (result_count < issued_count) begin
            idle_cycle();
        end
    endtask

    task automatic make_tile(input logic [31:0] seed);
        wt_state = lcg_step(SEED ^ seed);
        for (int k = 0; k < N; k++) begin
            shadow_rows[k] = random_row();
        end
    endtask

    task automatic activate_tile();
        for (int k = 0; k < N; k++) begin
            active_rows[k] = shadow_rows[k];
        end
    endtask

    // last row of a tile whose swap is already due
    task automatic load_last_row();
        apply_cycle(1'b0, 1'b1, shadow_rows[N-1], 1'b0, '0);
        idle_cycle();
        idle_cycle();
        check_value("shadow_full_o", RB'(shadow_full_o), 1);
        idle_cycle();
        check_value("shadow_full_o", RB'(shadow_full_o), '0);
        activate_tile();
    endtask

    task automatic compute_and_load(input int n_beats, input int n_loads, input logic use_stall);
        int        nb = 0;
        int        nl = 0;
        logic      ld;
        wt_vec_t   row;
        act_beat_t b;
        while (nb < n_beats || nl < n_loads) begin
            if (use_stall && stall_draw()) begin
                b.valid = 1'b1;
                b.vec   = random_act();
                apply_cycle(1'b1, 1'b1, random_row(), 1'b0, b);    // dropped by the DUT
            end else begin
                ld  = (nl < n_loads);
                row = '0;
                if (ld) begin
                    row = shadow_rows[nl];
                end
                b.valid = (nb < n_beats);
                b.vec   = '0;
                if (b.valid) begin
                    b.vec = random_act();
                end
                apply_cycle(1'b0, ld, row, 1'b0, b);
                if (b.valid) begin
                    nb++;
                    issued_count++;
                end
                if (ld) begin
                    nl++;
                end
            end
        end
    endtask

    task automatic run_test(input int idx);
        test_entry_t t;
        int          errors_before;
        int          stalls_before;
        int          beats_before;
        t             = tests[idx];
        errors_before = error_count;
        stalls_before = stall_count;
        beats_before  = beat_count;
        make_tile(t.tile_seed);
        stall_state = SEED ^ t.stall_seed;
        check_value("shadow_full_o", RB'(shadow_full_o), '0);
        compute_and_load(t.n_beats, t.early ? N - 1 : N, t.stall_seed != 0);
        drain_results();
        if (t.early) begin
            check_value("shadow_full_o", RB'(shadow_full_o), '0);
            apply_cycle(1'b0, 1'b0, '0, 1'b1, '0);    // swap goes pending
            beat_cycle();
            beat_cycle();
            drain_results();
            check_value("shadow_full_o", RB'(shadow_full_o), '0);
            load_last_row();
        end else begin
            check_value("shadow_full_o", RB'(shadow_full_o), 1);
            apply_cycle(1'b0, 1'b0, '0, 1'b1, '0);
            idle_cycle();
            idle_cycle();
            check_value("shadow_full_o", RB'(shadow_full_o), '0);
            activate_tile();
        end
        repeat (N) beat_cycle();    // new tile in use
        drain_results();
        $display("test %0d: %s, %0d beats, %0d stall cycles, %0d errors", idx,
                 (error_count == errors_before) ? "ok" : "FAILED", beat_count - beats_before,
                 stall_count - stalls_before, error_count - errors_before);
    endtask

    always @(posedge clk_i) begin : monitor
        flight_t leaving;
        flight_t entering;
        cycle_count++;
        if (!rst_i) begin
            if (!stall_i && res_o.valid) begin
                if (flight_q.size() == 0) begin
                    $display("result valid at %0t ns with no beat in flight", $time);
                    error_count++;
                end else begin
                    leaving = flight_q.pop_front();
                    for (int r = 0; r < N; r++) begin
                        check_value($sformatf("res_o.vec[%0d]", r), res_o.vec[r], leaving.vec[r]);
                    end
                    check_value("res_o latency", cycle_count - leaving.cyc,
                                LATENCY + stall_count - leaving.stalls);
                    result_count++;
                end
            end
            if (!stall_i && act_i.valid) begin
                entering.vec    = model_result(act_i.vec);
                entering.cyc    = cycle_count;
                entering.stalls = stall_count;
                flight_q.push_back(entering);
                beat_count++;
            end
            if (stall_i) begin
                stall_count++;
            end
        end
    end

    initial begin : watchdog
        int limit;
        @(posedge clk_i);
        limit = 3 * (8 + 6 * N);
        for (int i = 0; i < NUM_TESTS; i++) begin
            limit += 3 * (tests[i].n_beats + 2 + N + N + 4 * N);
        end
        repeat (limit) @(posedge clk_i);
        $display("watchdog timed out after %0d cycles", limit);
        $display("Test failures found");
        $finish;
    end

    initial begin
        clk_i       = 1'b0;
        rst_i       = 1'b1;
        stall_i     = 1'b0;
        wt_load_i   = 1'b0;
        wt_row_i    = '0;
        next_tile_i = 1'b0;
        act_i       = '0;
        data_state  = SEED;
        wt_state    = SEED;
        stall_state = SEED;
        tests[0] = '{32'h0000_0011, 32'd12, 32'h0000_0000, 1'b0};    // back to back
        tests[1] = '{32'h0000_0022, 32'd10, 32'h0000_0000, 1'b1};
        tests[2] = '{32'h0000_0033, 32'd16, 32'h0000_05a5, 1'b0};
        tests[3] = '{32'h0000_0044, 32'd14, 32'h0000_03c3, 1'b1};
        tests[4] = '{32'h0000_0055, 32'd3,  32'h0000_0000, 1'b0};    // loads outlast beats
        tests[5] = '{32'h0000_0066, 32'd20, 32'h0000_0777, 1'b0};
        repeat (8) @(posedge clk_i);
        rst_i <= 1'b0;
        repeat (3) begin
            idle_cycle();
            check_value("shadow_full_o", RB'(shadow_full_o), '0);
            check_value("res_o.valid", RB'(res_o.valid), '0);
        end
        make_tile(32'h0);
        for (int k = 0; k < N - 1; k++) begin
            apply_cycle(1'b0, 1'b1, shadow_rows[k], 1'b0, '0);
        end
        load_last_row();    // first tile swaps in without a request
        for (int i = 0; i < NUM_TESTS; i++) begin
            run_test(i);
        end
        $display("%0d tests, %0d beats, %0d checks, %0d errors",
                 NUM_TESTS, beat_count, check_count, error_count);
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* vlog.f */
+incdir+logic
logic/tpu_pkg.sv
logic/mac_cell.sv
logic/weight_bank_ctrl.sv
logic/act_skew.sv
logic/result_deskew.sv
logic/systolic_array.sv
logic/tpu_core.sv
tb/tb_tpu_core.sv
